//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_spi_master \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/spi_clk_gen.sv
`timescale 1ns/10ps
`include "spi_config.svh"

module spi_clk_gen (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               sclk_en,
  output logic               sclk,
  output spi_pkg::spi_edge_t sclk_edge
);

  localparam int DIV_W = $clog2(`SPI_CLK_DIV);

  logic [DIV_W-1:0] div_cnt;
  logic             half;

  assign half = run && (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (!run || half)
      div_cnt <= '0;     // Restart the half-period.
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sclk <= 1'b0;
    else if (!sclk_en)
      sclk <= 1'b0;      // Mode 0 idles low.
    else if (half)
      sclk <= ~sclk;
  end

  // Strobes lead the pin by the register stage, so users act on the same clk edge.
  assign sclk_edge.half = half;
  assign sclk_edge.rise = half && sclk_en && !sclk;
  assign sclk_edge.fall = half && sclk_en && sclk;

endmodule

//--- hdl/spi_cmd_ctrl.sv
`timescale 1ns/10ps
`include "spi_config.svh"

module spi_cmd_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::spi_cmd_t  cmd,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               cs,
  input  spi_pkg::spi_edge_t sclk_edge,
  output logic               run,
  output logic               sclk_en,
  output logic               load,
  output spi_pkg::spi_cmd_t  cmd_q,
  output logic               shift_en,
  output logic               capture_en,
  output logic               commit
);

  import spi_pkg::*;

  localparam bit_cnt_t CMD_BITS = bit_cnt_t'(`SPI_CMD_WIDTH);
  localparam bit_cnt_t ALL_BITS = bit_cnt_t'(`SPI_CMD_WIDTH + `SPI_READ_WIDTH);

  spi_state_e state;
  spi_state_e state_nxt;
  bit_cnt_t   bit_cnt;
  bit_cnt_t   last_bit;
  logic       accept;

  assign accept   = cmd_vld && cmd_rdy;
  assign last_bit = cmd_q.rw ? CMD_BITS : ALL_BITS;   // Reads clock 8 more bits.

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (cmd_vld)
          state_nxt = SETUP;
      end
      SETUP:
      begin
        if (sclk_edge.rise)
          state_nxt = SHIFT_CMD;                      // First rise ends setup.
      end
      SHIFT_CMD:
      begin
        if (sclk_edge.fall && bit_cnt == CMD_BITS)
          state_nxt = (bit_cnt == last_bit) ? HOLD : SHIFT_READ;
      end
      SHIFT_READ:
      begin
        if (sclk_edge.fall && bit_cnt == last_bit)
          state_nxt = HOLD;
      end
      HOLD:
      begin
        if (sclk_edge.half)
          state_nxt = DONE;
      end
      DONE:
      begin
        state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      cs      <= 1'b1;
      load    <= 1'b0;
      bit_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      cs    <= (state_nxt == IDLE) || (state_nxt == DONE);
      load  <= accept;                               // First SETUP cycle.
      if (accept)
        bit_cnt <= '0;
      else if (sclk_edge.rise)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
  end

  assign cmd_rdy    = (state == IDLE);
  assign run        = (state == SETUP) || (state == SHIFT_CMD) ||
                      (state == SHIFT_READ) || (state == HOLD);
  assign sclk_en    = (state == SETUP) || (state == SHIFT_CMD) || (state == SHIFT_READ);
  assign shift_en   = (state == SHIFT_CMD) || (state == SHIFT_READ);
  assign capture_en = (state == SHIFT_READ);
  assign commit     = (state == DONE) && !cmd_q.rw;  // Reads only.

endmodule

//--- hdl/spi_config.svh
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// Length of the command word whose MSB selects write (1) or read (0).
`define SPI_CMD_WIDTH  12

// Bits clocked back from the slave on a read.
`define SPI_READ_WIDTH 8

// Cycles of clk per sclk half-period.
`define SPI_CLK_DIV    4

`endif

//--- hdl/spi_master.sv
`timescale 1ns/10ps

module spi_master (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::cmd_word_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                sclk,
  output logic                cs,
  output logic                mosi,
  input  logic                miso,
  output logic                read_vld,
  output spi_pkg::read_word_t read_data
);

  import spi_pkg::*;

  spi_edge_t sclk_edge;
  spi_cmd_t  cmd_q;
  logic      run;
  logic      sclk_en;
  logic      load;
  logic      shift_en;
  logic      capture_en;
  logic      commit;

  spi_cmd_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (spi_cmd_t'(cmd_in)),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .cs         (cs),
    .sclk_edge  (sclk_edge),
    .run        (run),
    .sclk_en    (sclk_en),
    .load       (load),
    .cmd_q      (cmd_q),
    .shift_en   (shift_en),
    .capture_en (capture_en),
    .commit     (commit)
  );

  spi_clk_gen u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .sclk_en   (sclk_en),
    .sclk      (sclk),
    .sclk_edge (sclk_edge)
  );

  spi_tx_shift u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .cmd       (cmd_q),
    .shift_en  (shift_en),
    .sclk_edge (sclk_edge),
    .mosi      (mosi)
  );

  spi_rx_shift u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .miso       (miso),
    .capture_en (capture_en),
    .commit     (commit),
    .sclk_edge  (sclk_edge),
    .read_data  (read_data),
    .read_vld   (read_vld)
  );

endmodule

//--- hdl/spi_pkg.sv
`include "spi_config.svh"

package spi_pkg;

  typedef logic [`SPI_CMD_WIDTH-1:0]  cmd_word_t;
  typedef logic [`SPI_READ_WIDTH-1:0] read_word_t;
  typedef logic [4:0]                 bit_cnt_t;   // Counts up to 20 rising edges.

  typedef struct packed {
    logic       rw;     // 1 means write.
    logic [2:0] addr;
    logic [7:0] wdata;
  } spi_cmd_t;

  typedef struct packed {
    logic half;         // Every half-period boundary.
    logic rise;         // sclk goes high.
    logic fall;         // sclk goes low.
  } spi_edge_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    SHIFT_CMD,
    SHIFT_READ,
    HOLD,
    DONE
  } spi_state_e;

endpackage

//--- hdl/spi_rx_shift.sv
`timescale 1ns/10ps
`include "spi_config.svh"

module spi_rx_shift (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                miso,
  input  logic                capture_en,
  input  logic                commit,
  input  spi_pkg::spi_edge_t  sclk_edge,
  output spi_pkg::read_word_t read_data,
  output logic                read_vld
);

  import spi_pkg::*;

  read_word_t rx_q;

  always_ff @(posedge clk)
  begin
    if (capture_en && sclk_edge.rise)
      rx_q <= {rx_q[`SPI_READ_WIDTH-2:0], miso};  // Sampled on rising sclk.
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= commit;
      if (commit)
        read_data <= rx_q;                         // Held until the next read.
    end
  end

endmodule

//--- hdl/spi_tx_shift.sv
`timescale 1ns/10ps
`include "spi_config.svh"

module spi_tx_shift (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load,
  input  spi_pkg::spi_cmd_t  cmd,
  input  logic               shift_en,
  input  spi_pkg::spi_edge_t sclk_edge,
  output logic               mosi
);

  import spi_pkg::*;

  cmd_word_t tx_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_q <= '0;
    else if (load)
      tx_q <= cmd_word_t'(cmd);
    else if (shift_en && sclk_edge.fall)
      tx_q <= {tx_q[`SPI_CMD_WIDTH-2:0], 1'b0};   // Zeros fill in behind.
  end

  assign mosi = tx_q[`SPI_CMD_WIDTH-1];            // MSB first.

endmodule

//--- project.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_clk_gen.sv
hdl/spi_tx_shift.sv
hdl/spi_rx_shift.sv
hdl/spi_cmd_ctrl.sv
hdl/spi_master.sv
testbench/spi_master_chk.sv
testbench/tb_spi_master.sv

//--- testbench/spi_master_chk.sv
`timescale 1ns/10ps

module spi_master_chk (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic sclk,
  input logic cs,
  input logic mosi,
  input logic read_vld
);

  logic first_cmd_seen;
  int   idle_errs  = 0;
  int   rdy_errs   = 0;
  int   sclk_errs  = 0;
  int   cs_errs    = 0;
  int   pulse_errs = 0;
  int   fail_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      first_cmd_seen <= 1'b0;
    else if (cmd_vld && cmd_rdy)
      first_cmd_seen <= 1'b1;
  end

  always_comb
    fail_cnt = idle_errs + rdy_errs + sclk_errs + cs_errs + pulse_errs;

  idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !first_cmd_seen |-> cs && !sclk && !mosi && cmd_rdy && !read_vld)
  else
  begin
    $error("bus not idle before the first command");
    idle_errs++;
  end

  busy_while_selected: assert property (@(posedge clk) disable iff (!rst_n)
    !cs |-> !cmd_rdy)
  else
  begin
    $error("cmd_rdy high while cs is low");
    rdy_errs++;
  end

  sclk_low_deselected: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk)
  else
  begin
    $error("sclk high while cs is high");
    sclk_errs++;
  end

  cs_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cs)
  else
  begin
    $error("cs did not fall after a command was accepted");
    cs_errs++;
  end

  read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
  else
  begin
    $error("read_vld held longer than one cycle");
    pulse_errs++;
  end

endmodule

bind spi_master spi_master_chk chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .sclk     (sclk),
  .cs       (cs),
  .mosi     (mosi),
  .read_vld (read_vld)
);

//--- testbench/tb_spi_master.sv
`timescale 1ns/10ps
`include "spi_config.svh"

module tb_spi_master;

  import spi_pkg::*;

  localparam int N_WR  = 6;
  localparam int N_RD  = 6;
  localparam int N_MIX = 6;
  localparam int N_B2B = 8;
  localparam int N_CMDS = N_WR + N_RD + N_MIX + N_B2B;

  // A read plus two bit times of margin.
  localparam int TXN_CYCLES = (`SPI_CMD_WIDTH + `SPI_READ_WIDTH + 2) * 2 * `SPI_CLK_DIV;
  localparam int WATCHDOG_CYCLES = N_CMDS * TXN_CYCLES + 200;

  localparam int KIND_WRITE  = 0;
  localparam int KIND_READ   = 1;
  localparam int KIND_MIX    = 2;
  localparam int KIND_RANDOM = 3;

  logic       clk     = 1'b0;
  logic       rst_n   = 1'b0;
  cmd_word_t  cmd_in  = '0;
  logic       cmd_vld = 1'b0;
  logic       miso    = 1'b0;
  logic       cmd_rdy;
  logic       sclk;
  logic       cs;
  logic       mosi;
  logic       read_vld;
  read_word_t read_data;

  int         seed = 2157;
  int         rnd;
  cmd_word_t  exp_q[$];     // Accepted commands in issue order.
  read_word_t sent_q[$];    // Slave bytes not yet seen on read_data.
  cmd_word_t  batch_q[$];
  int         issued       = 0;
  int         done_cnt     = 0;
  int         model_errs   = 0;
  int         test_errs    = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;

  logic       sclk_d;
  logic       cs_d;
  cmd_word_t  shift_in;
  read_word_t tx_shift;
  read_word_t tx_byte;
  read_word_t held_data;
  cmd_word_t  exp_cmd;
  read_word_t exp_byte;
  int         rise_cnt;
  int         fall_cnt;
  int         exp_rises;

  spi_master uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  always #5 clk = ~clk;

  function automatic void show_mismatch(string msg);
    $display("** Error at %0t ns: %s", $time, msg);
  endfunction

  function automatic void show_fault(string msg);
    $display("Failure at %0t ns: %s", $time, msg);
  endfunction

  function automatic int total_errors();
    return model_errs + test_errs + uut.chk.fail_cnt;
  endfunction

  // Slave model and scoreboard. Pins are sampled one clk after they move.
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_d    = 1'b0;
      cs_d      = 1'b1;
      rise_cnt  = 0;
      fall_cnt  = 0;
      shift_in  = '0;
      tx_shift  = '0;
      held_data = '0;
      miso     <= 1'b0;
    end
    else
    begin
      if (cs_d && !cs)
      begin
        rise_cnt = 0;
        fall_cnt = 0;
        shift_in = '0;
        rnd      = $random(seed);
        tx_byte  = rnd[`SPI_READ_WIDTH-1:0];
        tx_shift = tx_byte;
      end
      if (!cs && sclk && !sclk_d)
      begin
        rise_cnt++;
        if (rise_cnt <= `SPI_CMD_WIDTH)
          shift_in = {shift_in[`SPI_CMD_WIDTH-2:0], mosi};
      end
      if (!cs && !sclk && sclk_d)
      begin
        fall_cnt++;
        if (!shift_in[`SPI_CMD_WIDTH-1] && fall_cnt >= `SPI_CMD_WIDTH &&
            fall_cnt < `SPI_CMD_WIDTH + `SPI_READ_WIDTH)
        begin
          miso    <= tx_shift[`SPI_READ_WIDTH-1];       // MSB first.
          tx_shift = {tx_shift[`SPI_READ_WIDTH-2:0], 1'b0};
        end
      end
      if (!cs_d && cs)
      begin
        if (exp_q.size() == 0)
        begin
          show_fault("bus transaction seen with no command accepted");
          model_errs++;
        end
        else
        begin
          exp_cmd   = exp_q.pop_front();
          exp_rises = exp_cmd[`SPI_CMD_WIDTH-1] ? `SPI_CMD_WIDTH :
                      `SPI_CMD_WIDTH + `SPI_READ_WIDTH;
          assert (shift_in == exp_cmd)
          else
          begin
            show_mismatch($sformatf("mosi carried %03h, expected %03h", shift_in, exp_cmd));
            model_errs++;
          end
          assert (rise_cnt == exp_rises)
          else
          begin
            show_mismatch($sformatf("%0d sclk rises, expected %0d", rise_cnt, exp_rises));
            model_errs++;
          end
          if (!exp_cmd[`SPI_CMD_WIDTH-1])
            sent_q.push_back(tx_byte);
        end
        miso     <= 1'b0;
        done_cnt <= done_cnt + 1;
      end
      if (read_vld)
      begin
        if (sent_q.size() == 0)
        begin
          show_fault("read_vld pulsed with no read outstanding");
          model_errs++;
        end
        else
        begin
          exp_byte = sent_q.pop_front();
          assert (read_data == exp_byte)
          else
          begin
            show_mismatch($sformatf("read_data %02h, expected %02h", read_data, exp_byte));
            model_errs++;
          end
          held_data = exp_byte;
        end
      end
      else
      begin
        assert (read_data == held_data)
        else
        begin
          show_mismatch($sformatf("read_data %02h changed, held %02h", read_data, held_data));
          model_errs++;
        end
      end
      sclk_d = sclk;
      cs_d   = cs;
    end
  end

  task automatic fill_batch(input int n, input int kind);
    int        i;
    int        r;
    logic      rw;
    cmd_word_t c;
    batch_q.delete();
    for (i = 0; i < n; i++)
    begin
      r = $random(seed);
      case (kind)
        KIND_WRITE: rw = 1'b1;
        KIND_READ:  rw = 1'b0;
        KIND_MIX:   rw = (i % 3 != 0);                 // One read then two writes.
        default:    rw = r[`SPI_CMD_WIDTH-1];
      endcase
      c = {rw, r[`SPI_CMD_WIDTH-2:0]};
      batch_q.push_back(c);
    end
  endtask

  // Called on a rising edge; returns on the edge that accepts the command.
  task automatic issue(input cmd_word_t c, input logic hold_vld);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    while (!cmd_rdy)
      @(posedge clk);
    exp_q.push_back(c);
    issued++;
    if (!hold_vld)
      cmd_vld <= 1'b0;
  endtask

  task automatic wait_done(input int target);
    while (done_cnt < target)
      @(posedge clk);
    repeat (2)
      @(posedge clk);                                 // read_vld trails cs.
  endtask

  task automatic run_batch(input logic hold_vld);
    int base;
    int i;
    base = done_cnt;
    for (i = 0; i < batch_q.size(); i++)
    begin
      issue(batch_q[i], hold_vld && (i < batch_q.size() - 1));
      if (!hold_vld)
        wait_done(base + i + 1);
    end
    wait_done(base + batch_q.size());
  endtask

  task automatic finish_test(input string name, input int errs_before);
    assert (done_cnt == issued)
    else
    begin
      show_fault($sformatf("%0d commands accepted but %0d transactions seen", issued, done_cnt));
      test_errs++;
    end
    assert (sent_q.size() == 0)
    else
    begin
      show_fault("a read finished on the bus but read_vld never followed");
      test_errs++;
    end
    if (total_errors() == errs_before)
    begin
      tests_passed++;
      $display("[PASS] %s", name);
    end
    else
    begin
      tests_failed++;
      $display("[FAIL] %s with %0d errors", name, total_errors() - errs_before);
    end
  endtask

  initial
  begin
    int errs;
    repeat (4)
      @(posedge clk);
    rst_n <= 1'b1;

    errs = total_errors();
    repeat (16)
      @(posedge clk);                                 // Idle bus watched by the checker.
    finish_test("reset_idle", errs);

    errs = total_errors();
    fill_batch(N_WR, KIND_WRITE);
    run_batch(1'b0);
    finish_test("write_cmds", errs);

    errs = total_errors();
    fill_batch(N_RD, KIND_READ);
    run_batch(1'b0);
    finish_test("read_cmds", errs);

    errs = total_errors();
    fill_batch(N_MIX, KIND_MIX);
    run_batch(1'b0);
    finish_test("write_after_read", errs);

    errs = total_errors();
    fill_batch(N_B2B, KIND_RANDOM);
    run_batch(1'b1);
    finish_test("back_to_back", errs);

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES)
      @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule
